//--- verilog/dnc_pkg.sv
package dnc_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Fixed-point and bus types
  //////////////////////////////////////////////////////////////////////////

  // Signed Q8.8 value
  typedef logic signed [15:0] data_t;

  // Word address into the interface memory
  typedef logic [5:0] addr_t;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
  } wb_req_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic  ack;
    data_t dat;
  } wb_rsp_t;

  // Steps shared by both squashing units
  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_squash,
    st_write
  } unit_state_t;

  //////////////////////////////////////////////////////////////////////////
  // Memory map
  //////////////////////////////////////////////////////////////////////////

  localparam int mem_words   = 64;
  localparam int max_w       = 16;
  localparam int num_masters = 3;

  // Raw and squashed erase vectors
  localparam addr_t erase_in_base  = 6'd0;
  localparam addr_t erase_out_base = 6'd16;
  // Allocation gate, write gate, write strength
  localparam addr_t gate_in_base   = 6'd32;
  localparam addr_t gate_out_base  = 6'd40;

  //////////////////////////////////////////////////////////////////////////
  // Q8.8 constants for the PLAN segments
  //////////////////////////////////////////////////////////////////////////

  localparam data_t q_one = 16'sh0100;
  localparam data_t q_max = 16'sh7fff;

  // Magnitude breakpoints, 5.0 / 2.375 / 1.0
  localparam logic [15:0] plan_a_sat = 16'h0500;
  localparam logic [15:0] plan_a_mid = 16'h0260;
  localparam logic [15:0] plan_a_low = 16'h0100;

  // Segment offsets, 0.84375 / 0.625 / 0.5
  localparam logic [15:0] plan_off_hi  = 16'h00d8;
  localparam logic [15:0] plan_off_mid = 16'h00a0;
  localparam logic [15:0] plan_off_low = 16'h0080;

endpackage

//--- verilog/dnc_logistic.sv
`timescale 1ns/1ns

module dnc_logistic (
  input  logic           clk,
  input  logic           reset,
  input  logic           in_valid,
  input  dnc_pkg::data_t x,
  output logic           out_valid,
  output dnc_pkg::data_t y
);

  import dnc_pkg::*;

  // Magnitude, always positive even for the most negative input
  logic [15:0] a;
  // Segment value for the folded input
  logic [15:0] seg;
  data_t       y_next;

  always_comb begin
    a = x[15] ? (~x + 16'd1) : x;

    // Pick the PLAN segment by magnitude
    if (a >= plan_a_sat) begin
      seg = q_one;
    end else if (a >= plan_a_mid) begin
      seg = (a >> 5) + plan_off_hi;
    end else if (a >= plan_a_low) begin
      seg = (a >> 3) + plan_off_mid;
    end else begin
      seg = (a >> 2) + plan_off_low;
    end

    // Unfold around 0.5 for negative inputs
    y_next = x[15] ? (q_one - data_t'(seg)) : data_t'(seg);
  end

  // One value in, one result a cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Result holds until the next input
  always_ff @(posedge clk) begin
    if (in_valid) begin
      y <= y_next;
    end
  end

endmodule

//--- verilog/dnc_erase_vector.sv
`timescale 1ns/1ns

module dnc_erase_vector (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic [4:0]       size_w,
  output logic             ready,
  output logic             done,
  output dnc_pkg::wb_req_t wb_req,
  input  dnc_pkg::wb_rsp_t wb_rsp
);

  import dnc_pkg::*;

  unit_state_t state;
  // Latched vector length
  logic [4:0]  size_q;
  // Element index
  logic [3:0]  k;
  logic        last_elem;
  logic        rd_ack;
  logic        wr_ack;
  logic        lgc_valid;
  data_t       lgc_y;

  assign ready     = (state == st_idle);
  assign rd_ack    = (state == st_read) && wb_rsp.ack;
  assign wr_ack    = (state == st_write) && wb_rsp.ack;
  // Zero length behaves as one element
  assign last_elem = ({1'b0, k} + 5'd1) >= size_q;
  assign done      = wr_ack && last_elem;

  //////////////////////////////////////////////////////////////////////////
  // Element loop
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= st_idle;
      size_q <= 5'd0;
      k      <= 4'd0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            size_q <= (size_w > 5'(max_w)) ? 5'(max_w) : size_w;
            k      <= 4'd0;
            state  <= st_read;
          end
        end
        st_read: begin
          if (rd_ack) state <= st_squash;
        end
        // Logistic result lands one cycle after the read
        st_squash: begin
          if (lgc_valid) state <= st_write;
        end
        st_write: begin
          if (wr_ack) begin
            k     <= k + 4'd1;
            state <= last_elem ? st_idle : st_read;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Raw word goes straight into the squasher
  dnc_logistic logistic_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (rd_ack),
    .x         (wb_rsp.dat),
    .out_valid (lgc_valid),
    .y         (lgc_y)
  );

  // Bus held for the whole run, strobe only on accesses
  always_comb begin
    wb_req     = '0;
    wb_req.cyc = (state != st_idle);
    wb_req.stb = (state == st_read) || (state == st_write);
    wb_req.we  = (state == st_write);
    wb_req.adr = (state == st_write) ? (erase_out_base + {2'b00, k})
                                     : (erase_in_base + {2'b00, k});
    wb_req.dat = lgc_y;
  end

endmodule

//--- verilog/dnc_write_gates.sv
`timescale 1ns/1ns

module dnc_write_gates (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  output logic             ready,
  output logic             done,
  output dnc_pkg::wb_req_t wb_req,
  input  dnc_pkg::wb_rsp_t wb_rsp
);

  import dnc_pkg::*;

  unit_state_t        state;
  // 0 alloc gate, 1 write gate, 2 strength
  logic [1:0]         sel;
  logic               rd_ack;
  logic               wr_ack;
  logic               lgc_valid;
  data_t              lgc_y;
  data_t              raw_q;
  data_t              wdat_q;
  data_t              strength;
  logic signed [16:0] sum;

  assign ready  = (state == st_idle);
  assign rd_ack = (state == st_read) && wb_rsp.ack;
  assign wr_ack = (state == st_write) && wb_rsp.ack;
  assign done   = wr_ack && (sel == 2'd2);

  // Oneplus, saturating on the positive side
  always_comb begin
    sum = {raw_q[15], raw_q} + {q_one[15], q_one};
    if (raw_q > 16'sd0) begin
      strength = (sum > 17'sh07fff) ? q_max : sum[15:0];
    end else begin
      strength = lgc_y + q_one;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      sel   <= 2'd0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            sel   <= 2'd0;
            state <= st_read;
          end
        end
        st_read:   if (rd_ack) state <= st_squash;
        st_squash: if (lgc_valid) state <= st_write;
        st_write: begin
          if (wr_ack) begin
            sel   <= sel + 2'd1;
            state <= (sel == 2'd2) ? st_idle : st_read;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Raw value kept for the oneplus sign test
  always_ff @(posedge clk) begin
    if (rd_ack) raw_q <= wb_rsp.dat;
    if ((state == st_squash) && lgc_valid) begin
      wdat_q <= (sel == 2'd2) ? strength : lgc_y;
    end
  end

  dnc_logistic logistic_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (rd_ack),
    .x         (wb_rsp.dat),
    .out_valid (lgc_valid),
    .y         (lgc_y)
  );

  always_comb begin
    wb_req     = '0;
    wb_req.cyc = (state != st_idle);
    wb_req.stb = (state == st_read) || (state == st_write);
    wb_req.we  = (state == st_write);
    wb_req.adr = (state == st_write) ? (gate_out_base + {4'b0000, sel})
                                     : (gate_in_base + {4'b0000, sel});
    wb_req.dat = wdat_q;
  end

endmodule

//--- verilog/dnc_wb_arbiter.sv
`timescale 1ns/1ns

module dnc_wb_arbiter #(
  parameter int num_ports = dnc_pkg::num_masters
) (
  input  logic             clk,
  input  logic             reset,
  input  dnc_pkg::wb_req_t m_req [num_ports],
  output dnc_pkg::wb_rsp_t m_rsp [num_ports],
  output dnc_pkg::wb_req_t s_req,
  input  dnc_pkg::wb_rsp_t s_rsp
);

  localparam int idx_w = (num_ports > 1) ? $clog2(num_ports) : 1;

  // Current owner of the slave
  logic [idx_w-1:0] owner;
  // Last winner, round-robin starts after it
  logic [idx_w-1:0] last;
  logic             locked;
  logic [idx_w-1:0] pick;
  logic             pick_any;

  // Nearest requester after the last winner
  always_comb begin
    int idx;
    pick     = last;
    pick_any = 1'b0;
    // Walk backwards so the closest one is assigned last
    for (int off = num_ports; off >= 1; off--) begin
      idx = (int'(last) + off) % num_ports;
      if (m_req[idx].cyc) begin
        pick     = idx_w'(idx);
        pick_any = 1'b1;
      end
    end
  end

  // Grant held while the owner keeps cyc
  always_ff @(posedge clk) begin
    if (reset) begin
      owner  <= '0;
      last   <= idx_w'(num_ports - 1);
      locked <= 1'b0;
    end else if (!locked || !m_req[owner].cyc) begin
      locked <= pick_any;
      if (pick_any) begin
        owner <= pick;
        last  <= pick;
      end
    end
  end

  assign s_req = locked ? m_req[owner] : '0;

  // Ack only to the owner, read data to all
  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      m_rsp[i].dat = s_rsp.dat;
      m_rsp[i].ack = s_rsp.ack && locked && (int'(owner) == i);
    end
  end

endmodule

//--- verilog/dnc_interface_ram.sv
`timescale 1ns/1ns

module dnc_interface_ram (
  input  logic             clk,
  input  logic             reset,
  input  dnc_pkg::wb_req_t wb_req,
  output dnc_pkg::wb_rsp_t wb_rsp
);

  import dnc_pkg::*;

  data_t mem [mem_words];
  logic  ack_q;
  data_t rdat_q;
  logic  accept;

  // Skip the cycle after an ack so a held strobe is seen once
  assign accept = wb_req.cyc && wb_req.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // Write on accept, read data valid with ack
  always_ff @(posedge clk) begin
    if (accept) begin
      if (wb_req.we) begin
        mem[wb_req.adr] <= wb_req.dat;
      end
      rdat_q <= mem[wb_req.adr];
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdat_q;

endmodule

//--- verilog/dnc_interface_top.sv
`timescale 1ns/1ns

module dnc_interface_top (
  input  logic             clk,
  input  logic             reset,
  input  dnc_pkg::wb_req_t host_req,
  output dnc_pkg::wb_rsp_t host_rsp,
  input  logic             erase_start,
  input  logic [4:0]       size_w,
  output logic             erase_ready,
  output logic             erase_done,
  input  logic             gates_start,
  output logic             gates_ready,
  output logic             gates_done
);

  import dnc_pkg::*;

  // Port 0 host, 1 erase, 2 gates
  wb_req_t m_req [num_masters];
  wb_rsp_t m_rsp [num_masters];
  wb_req_t s_req;
  wb_rsp_t s_rsp;

  assign m_req[0] = host_req;
  assign host_rsp = m_rsp[0];

  dnc_erase_vector erase_i (
    .clk    (clk),
    .reset  (reset),
    .start  (erase_start),
    .size_w (size_w),
    .ready  (erase_ready),
    .done   (erase_done),
    .wb_req (m_req[1]),
    .wb_rsp (m_rsp[1])
  );

  dnc_write_gates gates_i (
    .clk    (clk),
    .reset  (reset),
    .start  (gates_start),
    .ready  (gates_ready),
    .done   (gates_done),
    .wb_req (m_req[2]),
    .wb_rsp (m_rsp[2])
  );

  dnc_wb_arbiter #(.num_ports(num_masters)) arbiter_i (
    .clk   (clk),
    .reset (reset),
    .m_req (m_req),
    .m_rsp (m_rsp),
    .s_req (s_req),
    .s_rsp (s_rsp)
  );

  // Single shared memory behind the arbiter
  dnc_interface_ram ram_i (
    .clk    (clk),
    .reset  (reset),
    .wb_req (s_req),
    .wb_rsp (s_rsp)
  );

endmodule

//--- bench/dnc_interface_checker.sv
`timescale 1ns/1ns

module dnc_interface_checker #(
  parameter int num_ports = dnc_pkg::num_masters
) (
  input logic             clk,
  input logic             reset,
  input dnc_pkg::wb_req_t m_req [num_ports],
  input dnc_pkg::wb_rsp_t m_rsp [num_ports],
  input dnc_pkg::wb_req_t s_req,
  input dnc_pkg::wb_rsp_t s_rsp
);

  // Per-master ack and active strobe
  logic [num_ports-1:0] acks;
  logic [num_ports-1:0] strobed;

  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      acks[i]    = m_rsp[i].ack;
      strobed[i] = m_req[i].cyc && m_req[i].stb;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Arbiter and memory bus
  ////////////////////////////////////////////////////////////////////////////

  ack_single: assert property (@(posedge clk) disable iff (reset) $onehot0(acks))
    else $error("more than one master acknowledged in one cycle");

  ack_to_requester: assert property (@(posedge clk) disable iff (reset)
    (acks & ~strobed) == '0)
    else $error("ack sent to a master without cyc and stb");

  // Held strobe acknowledged once
  mem_no_double_ack: assert property (@(posedge clk) disable iff (reset)
    s_rsp.ack |=> !s_rsp.ack)
    else $error("memory acknowledged two cycles in a row");

  // Accepted strobe answered next cycle
  mem_ack_follows: assert property (@(posedge clk) disable iff (reset)
    (s_req.cyc && s_req.stb && !s_rsp.ack) |=> s_rsp.ack)
    else $error("memory missed a strobed request");

endmodule

bind dnc_wb_arbiter dnc_interface_checker #(.num_ports(num_ports)) checker_i (
  .clk   (clk),
  .reset (reset),
  .m_req (m_req),
  .m_rsp (m_rsp),
  .s_req (s_req),
  .s_rsp (s_rsp)
);

//--- bench/dnc_interface_tb.sv
`timescale 1ns/1ns

module dnc_interface_tb;

  import dnc_pkg::*;

  logic       clk;
  logic       reset;
  wb_req_t    host_req;
  wb_rsp_t    host_rsp;
  logic       erase_start;
  logic [4:0] size_w;
  logic       erase_ready;
  logic       erase_done;
  logic       gates_start;
  logic       gates_ready;
  logic       gates_done;

  // Parsed command lines
  logic [7:0] cmd_q [$];
  int         arg_a_q [$];
  data_t      arg_v_q [$];

  // Words the host wrote as reference for random reads
  data_t shadow [mem_words];
  bit    shadow_valid [mem_words];

  int          erase_starts = 0;
  int          erase_dones = 0;
  int          gates_starts = 0;
  int          gates_dones = 0;
  int          mismatches = 0;
  int          failures = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  bit          limit_known = 1'b0;
  logic [31:0] lfsr_state;

  dnc_interface_top dnc_interface_top_i (
    .clk         (clk),
    .reset       (reset),
    .host_req    (host_req),
    .host_rsp    (host_rsp),
    .erase_start (erase_start),
    .size_w      (size_w),
    .erase_ready (erase_ready),
    .erase_done  (erase_done),
    .gates_start (gates_start),
    .gates_ready (gates_ready),
    .gates_done  (gates_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Done pulses counted at the edge that closes them
  always @(posedge clk) begin
    if (erase_done) erase_dones <= erase_dones + 1;
    if (gates_done) gates_dones <= gates_dones + 1;
  end

  // Watchdog
  initial begin
    wait (limit_known);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run still busy after %0d cycles", cycles);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random gaps and addresses
  ////////////////////////////////////////////////////////////////////////////

  // Galois step over taps 32 22 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [3:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Vector file
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_command(input logic [7:0] cmd, input int a, input data_t v);
    cmd_q.push_back(cmd);
    arg_a_q.push_back(a);
    arg_v_q.push_back(v);
  endtask

  task automatic load_vectors();
    int         fd;
    int         n;
    int         got;
    int         c;
    int         a;
    data_t      v;
    logic [7:0] cmd;
    fd = $fopen("bench/dnc_interface_vectors.txt", "r");
    if (fd == 0) begin
      failures++;
      $display("Error: cannot open bench/dnc_interface_vectors.txt");
    end else begin
      n = $fscanf(fd, " %c", cmd);
      while (n == 1) begin
        a = 0;
        v = '0;
        case (cmd)
          "#": begin
            // Comment runs to end of line
            c = $fgetc(fd);
            while (c != 10 && c != -1) c = $fgetc(fd);
          end
          "W", "R": begin
            got = $fscanf(fd, "%d %h", a, v);
            if (got != 2) begin
              failures++;
              $display("Error: command '%c' lacks its address or value", cmd);
            end
            add_command(cmd, a, v);
          end
          "E": begin
            got = $fscanf(fd, "%d", a);
            if (got != 1) begin
              failures++;
              $display("Error: erase command lacks its length");
            end
            add_command(cmd, a, v);
          end
          "G": add_command(cmd, a, v);
          default: begin
            failures++;
            $display("Error: unknown command '%c' in vector file", cmd);
          end
        endcase
        n = $fscanf(fd, " %c", cmd);
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Host port and unit control
  ////////////////////////////////////////////////////////////////////////////

  // Single access entered and left on a falling edge
  task automatic host_access(input logic we, input addr_t adr, input data_t wdat,
                             output data_t rdat);
    host_req.cyc = 1'b1;
    host_req.stb = 1'b1;
    host_req.we  = we;
    host_req.adr = adr;
    host_req.dat = wdat;
    @(negedge clk);
    while (!host_rsp.ack) @(negedge clk);
    rdat = host_rsp.dat;
    // Request held through the ack cycle
    @(negedge clk);
    host_req = '0;
  endtask

  // Random host reads of raw words while a unit is busy
  task automatic wait_idle();
    logic [3:0] gap;
    logic [3:0] pick;
    logic [3:0] sel;
    addr_t      adr;
    data_t      rdat;
    while (erase_dones < erase_starts || gates_dones < gates_starts) begin
      draw_bits(2, gap);
      repeat (int'(gap) + 1) @(negedge clk);
      draw_bits(1, pick);
      if (pick[0]) begin
        draw_bits(4, sel);
        adr = erase_in_base + addr_t'(sel);
        host_access(1'b0, adr, '0, rdat);
        if (shadow_valid[adr]) begin
          check_word(rdat, shadow[adr], $sformatf("busy read of word %0d", adr));
        end
      end
    end
    if (erase_dones != erase_starts || gates_dones != gates_starts) begin
      failures++;
      $display("Error at %0t ns: done pulses %0d/%0d do not match starts %0d/%0d",
               $time, erase_dones, gates_dones, erase_starts, gates_starts);
    end
    check_flag(erase_ready, 1'b1, "erase ready when idle");
    check_flag(gates_ready, 1'b1, "gates ready when idle");
  endtask

  task automatic start_erase(input logic [4:0] w);
    while (erase_dones < erase_starts) @(negedge clk);
    size_w      = w;
    erase_start = 1'b1;
    erase_starts++;
    @(negedge clk);
    erase_start = 1'b0;
    check_flag(erase_ready, 1'b0, "erase ready during run");
    // Second start with another length is ignored while busy
    size_w      = ~w;
    erase_start = 1'b1;
    @(negedge clk);
    erase_start = 1'b0;
  endtask

  task automatic start_gates();
    while (gates_dones < gates_starts) @(negedge clk);
    gates_start = 1'b1;
    gates_starts++;
    @(negedge clk);
    gates_start = 1'b0;
    check_flag(gates_ready, 1'b0, "gates ready during run");
    gates_start = 1'b1;
    @(negedge clk);
    gates_start = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    data_t rdat;
    addr_t adr;
    reset       = 1'b1;
    host_req    = '0;
    erase_start = 1'b0;
    size_w      = '0;
    gates_start = 1'b0;
    lfsr_state  = 32'h1745;
    load_vectors();
    // 200 cycles per command plus one slot for reset
    cycle_limit = 200 * (cmd_q.size() + 1);
    limit_known = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_flag(erase_ready, 1'b1, "erase ready after reset");
    check_flag(gates_ready, 1'b1, "gates ready after reset");
    check_flag(host_rsp.ack, 1'b0, "host ack after reset");
    for (int i = 0; i < cmd_q.size(); i++) begin
      adr = addr_t'(arg_a_q[i]);
      case (cmd_q[i])
        "W": begin
          wait_idle();
          host_access(1'b1, adr, arg_v_q[i], rdat);
          shadow[adr]       = arg_v_q[i];
          shadow_valid[adr] = 1'b1;
        end
        "R": begin
          wait_idle();
          host_access(1'b0, adr, '0, rdat);
          check_word(rdat, arg_v_q[i], $sformatf("word %0d", adr));
        end
        "E": start_erase(5'(arg_a_q[i]));
        default: start_gates();
      endcase
    end
    wait_idle();
    $display("Run ended with %0d mismatches and %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- bench/dnc_interface_vectors.txt
# W <addr> <hex value>: host write.  R <addr> <hex expected>: host read and compare
# E <size_w>: start erase unit.  G: start gate unit
# Raw erase values over all four segments and both signs
W 0 0000
W 1 0040
W 2 ffc0
W 3 00ff
W 4 0100
W 5 ff00
W 6 0180
W 7 025f
W 8 0260
W 9 fda0
W 10 0400
W 11 04ff
W 12 0500
W 13 fb00
W 14 7fff
W 15 8000
R 7 025f
R 15 8000
E 16
R 16 0080
R 17 0090
R 18 0070
R 19 00bf
R 20 00c0
R 21 0040
R 22 00d0
R 23 00eb
R 24 00eb
R 25 0015
R 26 00f8
R 27 00ff
R 28 0100
R 29 0000
R 30 0100
R 31 0000
# Short run, word 19 keeps its old result
W 0 0200
W 1 fe00
W 2 0300
W 3 0080
E 3
R 16 00e0
R 17 0020
R 18 00f0
R 19 00bf
# Gates, strength saturates
W 32 0180
W 33 fc00
W 34 7f80
G
R 40 00d0
R 41 0008
R 42 7fff
# Both units together
W 4 fe80
W 32 0000
W 33 0500
W 34 ff00
E 5
G
R 16 00e0
R 17 0020
R 18 00f0
R 19 00a0
R 20 0030
R 21 0040
R 40 0080
R 41 0100
R 42 0140

//--- project.f
verilog/dnc_pkg.sv
verilog/dnc_logistic.sv
verilog/dnc_erase_vector.sv
verilog/dnc_write_gates.sv
verilog/dnc_wb_arbiter.sv
verilog/dnc_interface_ram.sv
verilog/dnc_interface_top.sv
bench/dnc_interface_checker.sv
bench/dnc_interface_tb.sv

//--- Makefile
TOP := dnc_interface_tb

sim:
	verilator --binary --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
